//--- dcacheCredit.sv
`default_nettype none

module dcacheCredit (
    input  logic               clk,
    input  logic               arstN,
    input  pipeCtrlPkg::instrT mem1Instr,
    input  logic               mem1Wr,
    input  logic               dCredit,
    output pipeCtrlPkg::dReqT  dReq,
    output logic               dcacheBusy
);
    import pipeCtrlPkg::*;

    logic                memOp;
    logic [CREDIT_W-1:0] creditCnt;

    assign memOp = mem1Instr.valid && ((mem1Instr.op == OP_LOAD) || (mem1Instr.op == OP_STORE));

    // Out of credit with a memory op waiting stalls everything
    assign dcacheBusy = memOp && (creditCnt == '0);

    // One request per memory op, sent as it leaves MEM1
    always_comb begin
        dReq.valid   = memOp && mem1Wr && (creditCnt != '0);
        dReq.isStore = (mem1Instr.op == OP_STORE);
        dReq.addr    = mem1Instr.target;
    end

    // Request takes a credit, returned pulse gives one back
    // Both together cancel, count saturates at the full pool
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            creditCnt <= CREDIT_W'(DCACHE_CREDITS);
        end else begin
            case ({dReq.valid, dCredit})
                2'b10: creditCnt <= creditCnt - 1'b1;
                2'b01: begin
                    if (creditCnt != CREDIT_W'(DCACHE_CREDITS)) begin
                        creditCnt <= creditCnt + 1'b1;
                    end
                end
                default: creditCnt <= creditCnt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- flist.f
pipeCtrlPkg.sv
pipeConfig.sv
hazardDetect.sv
pipeControl.sv
mulDivSeq.sv
dcacheCredit.sv
stageRegs.sv
pipeTop.sv
pipeMonitor.sv
pipeTop_asserts.sv
tb_pipeTop.sv

//--- hazardDetect.sv
`default_nettype none

module hazardDetect (
    input  pipeCtrlPkg::instrT  idInstr,
    input  pipeCtrlPkg::instrT  exeInstr,
    input  pipeCtrlPkg::instrT  mem1Instr,
    input  pipeCtrlPkg::instrT  mem2Instr,
    output pipeCtrlPkg::hazardT hazard
);
    import pipeCtrlPkg::*;

    hazardT rsHaz;
    hazardT rtHaz;

    // Valid producer with a real destination equal to src
    function automatic logic writesReg(input instrT prod, input logic [REG_W-1:0] src);
        return prod.valid && (prod.rd != '0) && (prod.rd == src);
    endfunction

    // Youngest producer of src decides, older writers are shadowed
    function automatic hazardT srcHazard(input logic [REG_W-1:0] src,
                                         input instrT exeTok,
                                         input instrT mem1Tok,
                                         input instrT mem2Tok);
        hazardT h;
        h = '0;
        if (writesReg(exeTok, src)) begin
            // ALU result forwarded from EXE, load and mul/div are not
            h.exeHaz = (exeTok.op == OP_LOAD) || (exeTok.op == OP_MULDIV);
        end else if (writesReg(mem1Tok, src)) begin
            h.mem1Haz = (mem1Tok.op == OP_LOAD);
        end else if (writesReg(mem2Tok, src)) begin
            h.mem2Haz = (mem2Tok.op == OP_LOAD);
        end
        return h;
    endfunction

    // Register 0 cannot match since writesReg rejects rd 0
    always_comb begin
        rsHaz = srcHazard(idInstr.rs, exeInstr, mem1Instr, mem2Instr);
        rtHaz = srcHazard(idInstr.rt, exeInstr, mem1Instr, mem2Instr);
    end

    // Bubbles in ID never stall
    always_comb begin
        hazard.exeHaz  = idInstr.valid && (rsHaz.exeHaz || rtHaz.exeHaz);
        hazard.mem1Haz = idInstr.valid && (rsHaz.mem1Haz || rtHaz.mem1Haz);
        hazard.mem2Haz = idInstr.valid && (rsHaz.mem2Haz || rtHaz.mem2Haz);
    end

endmodule

`default_nettype wire

//--- mulDivSeq.sv
`default_nettype none

module mulDivSeq (
    input  logic                          clk,
    input  logic                          arstN,
    input  pipeCtrlPkg::instrT            exeInstr,
    input  logic                          exeWr,
    input  logic [pipeCtrlPkg::CFG_W-1:0] mulDivLat,
    output logic                          mdBusy
);
    import pipeCtrlPkg::*;

    logic             exeFresh;
    logic             mdStart;
    logic [CFG_W-1:0] mdCnt;

    // EXE holds a token that arrived on the last edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exeFresh <= 1'b0;
        end else begin
            exeFresh <= exeWr;
        end
    end

    assign mdStart = exeFresh && exeInstr.valid && (exeInstr.op == OP_MULDIV);

    // Arrival cycle counts as the first busy cycle
    assign mdBusy = mdStart ? (mulDivLat != '0) : (mdCnt != '0);

    // Remaining busy cycles after the current one
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mdCnt <= '0;
        end else if (mdStart) begin
            mdCnt <= (mulDivLat == '0) ? '0 : mulDivLat - 1'b1;
        end else if (mdCnt != '0) begin
            mdCnt <= mdCnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- pipeConfig.sv
`default_nettype none

module pipeConfig (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          cfgWrEn,
    input  logic                          cfgSel,
    input  logic [pipeCtrlPkg::CFG_W-1:0] cfgData,
    output logic [pipeCtrlPkg::CFG_W-1:0] mulDivLat,
    output logic [pipeCtrlPkg::PC_W-1:0]  excVector
);
    import pipeCtrlPkg::*;

    // Multiply/divide occupancy in cycles, selected by cfgSel low
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mulDivLat <= DEF_MULDIV_LAT;
        end else if (cfgWrEn && !cfgSel) begin
            mulDivLat <= cfgData;
        end
    end

    // Exception redirect target, selected by cfgSel high
    // Only the low PC_W bits of the write data matter
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            excVector <= DEF_EXC_VECTOR;
        end else if (cfgWrEn && cfgSel) begin
            excVector <= cfgData[PC_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- pipeControl.sv
`default_nettype none

module pipeControl (
    input  logic                    dcacheBusy,
    input  logic                    mdBusy,
    input  logic                    exceptInMem1,
    input  pipeCtrlPkg::hazardT     hazard,
    input  logic                    brMissInExe,
    input  logic                    jumpInId,
    output pipeCtrlPkg::stageCtrlT  ctrl,
    output pipeCtrlPkg::stallCauseE cause
);
    import pipeCtrlPkg::*;

    logic exeDisWr;

    // Priority chain, oldest and most blocking condition first
    always_comb begin
        if (dcacheBusy) begin
            cause = CAUSE_DCACHE;
        end else if (mdBusy) begin
            cause = CAUSE_MULDIV;
        end else if (exceptInMem1) begin
            cause = CAUSE_EXCEPT;
        end else if (hazard.mem2Haz) begin
            cause = CAUSE_DH_MEM2;
        end else if (hazard.mem1Haz) begin
            cause = CAUSE_DH_MEM1;
        end else if (hazard.exeHaz) begin
            cause = CAUSE_DH_EXE;
        end else if (brMissInExe) begin
            cause = CAUSE_BRMISS;
        end else if (jumpInId) begin
            cause = CAUSE_JUMP;
        end else begin
            cause = CAUSE_NONE;
        end
    end

    // EXE side effects off for exception, MEM1 hazard or busy mul/div
    // Independent of the chain above
    assign exeDisWr = exceptInMem1 || hazard.mem1Haz || mdBusy;

    // A flushed stage takes a bubble even when it is also written
    always_comb begin
        ctrl          = '0;
        ctrl.wr       = '1;
        ctrl.exeDisWr = exeDisWr;
        case (cause)
            CAUSE_DCACHE, CAUSE_MULDIV: begin
                // Whole pipe frozen
                ctrl.wr       = '0;
                ctrl.memDisWr = 1'b1;
            end
            CAUSE_EXCEPT: begin
                // Vector into PREIF, younger work dropped
                // Syscall itself moves on into MEM2
                ctrl.wr[S_MEM1:S_IF]    = '0;
                ctrl.flush[S_MEM1:S_IF] = '1;
                ctrl.memDisWr           = 1'b1;
            end
            CAUSE_DH_MEM2: begin
                // Hold up to MEM1, bubble into MEM2
                ctrl.wr[S_MEM1:S_PREIF] = '0;
                ctrl.flush[S_MEM2]      = 1'b1;
                ctrl.memDisWr           = 1'b1;
            end
            CAUSE_DH_MEM1: begin
                // Hold up to EXE, bubble into MEM1
                ctrl.wr[S_EXE:S_PREIF] = '0;
                ctrl.flush[S_MEM1]     = 1'b1;
            end
            CAUSE_DH_EXE: begin
                // Hold up to ID, bubble into EXE
                ctrl.wr[S_ID:S_PREIF] = '0;
                ctrl.flush[S_EXE]     = 1'b1;
                ctrl.idDisWr          = 1'b1;
            end
            CAUSE_BRMISS: begin
                // Redirect from EXE target
                // No delay slot, so the wrong-path ID token must not reach EXE
                ctrl.wr[S_ID:S_IF]     = '0;
                ctrl.flush[S_EXE:S_IF] = '1;
            end
            CAUSE_JUMP: begin
                // Redirect from ID target, jump itself goes on to EXE
                // ID refills from IF, so that copy is killed too
                ctrl.wr[S_IF]         = 1'b0;
                ctrl.flush[S_ID:S_IF] = '1;
            end
            default: begin
                // Free flow
                ctrl.wr = '1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- pipeCtrlPkg.sv
`default_nettype none

package pipeCtrlPkg;

    // Pipeline geometry
    localparam int STAGES = 7;
    localparam int PC_W   = 16;
    localparam int CFG_W  = 16;
    localparam int REG_W  = 5;

    // Stage index into the per-stage write and flush vectors
    localparam int S_PREIF = 0;
    localparam int S_IF    = 1;
    localparam int S_ID    = 2;
    localparam int S_EXE   = 3;
    localparam int S_MEM1  = 4;
    localparam int S_MEM2  = 5;
    localparam int S_WB    = 6;

    // Data cache request credits
    localparam int DCACHE_CREDITS = 2;
    localparam int CREDIT_W       = $clog2(DCACHE_CREDITS + 1);

    // Values after reset
    localparam logic [PC_W-1:0]  RESET_PC       = '0;
    localparam logic [CFG_W-1:0] DEF_MULDIV_LAT = 4;
    localparam logic [PC_W-1:0]  DEF_EXC_VECTOR = 16'h0100;

    typedef enum logic [2:0] {
        OP_ALU     = 3'd0,
        OP_LOAD    = 3'd1,
        OP_STORE   = 3'd2,
        OP_MULDIV  = 3'd3,
        OP_JUMP    = 3'd4,
        OP_BRMISS  = 3'd5,
        OP_SYSCALL = 3'd6
    } opcodeE;

    // Winning branch of the stall and flush priority chain
    typedef enum logic [3:0] {
        CAUSE_NONE    = 4'd0,
        CAUSE_DCACHE  = 4'd1,
        CAUSE_MULDIV  = 4'd2,
        CAUSE_EXCEPT  = 4'd3,
        CAUSE_DH_MEM2 = 4'd4,
        CAUSE_DH_MEM1 = 4'd5,
        CAUSE_DH_EXE  = 4'd6,
        CAUSE_BRMISS  = 4'd7,
        CAUSE_JUMP    = 4'd8
    } stallCauseE;

    // Instruction token, rd of zero means no register write
    typedef struct packed {
        logic             valid;
        opcodeE           op;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] rd;
        logic [PC_W-1:0]  pc;
        logic [PC_W-1:0]  target;
    } instrT;

    // Bit k of wr and flush belongs to stage k, flush of PREIF stays zero
    typedef struct packed {
        logic [STAGES-1:0] wr;
        logic [STAGES-1:0] flush;
        logic              idDisWr;
        logic              exeDisWr;
        logic              memDisWr;
    } stageCtrlT;

    typedef struct packed {
        logic exeHaz;
        logic mem1Haz;
        logic mem2Haz;
    } hazardT;

    typedef struct packed {
        logic            valid;
        logic            isStore;
        logic [PC_W-1:0] addr;
    } dReqT;

    typedef struct packed {
        logic             valid;
        logic [PC_W-1:0]  pc;
        logic [REG_W-1:0] rd;
    } retireT;

endpackage

`default_nettype wire

//--- pipeMonitor.sv
`default_nettype none

module pipeMonitor (
    input  logic                         clk,
    input  logic                         arstN,
    input  pipeCtrlPkg::instrT           prog [256],
    input  logic [pipeCtrlPkg::PC_W-1:0] fetchPc,
    input  pipeCtrlPkg::dReqT            dReq,
    input  logic                         dCredit,
    input  pipeCtrlPkg::retireT          retire,
    output int                           errCount,
    output int                           retiredCnt,
    output int                           reqCnt,
    output logic                         modelDone
);
    timeunit 1ns;
    timeprecision 100ps;
    import pipeCtrlPkg::*;

    localparam int HANDLER_BASE = 240;

    logic [PC_W-1:0] expPc;
    logic [PC_W-1:0] memPc;
    int              memRetired;
    int              outstanding;

    function automatic instrT progAt(input logic [PC_W-1:0] pc);
        logic [7:0] idx;
        if (pc < PC_W'(HANDLER_BASE)) begin
            return prog[pc[7:0]];
        end else if (pc >= DEF_EXC_VECTOR && pc < DEF_EXC_VECTOR + PC_W'(16)) begin
            idx = 8'(HANDLER_BASE) + 8'(pc - DEF_EXC_VECTOR);
            return prog[idx];
        end
        return '0;
    endfunction

    // Architectural successor
    function automatic logic [PC_W-1:0] archNext(input logic [PC_W-1:0] pc);
        instrT t;
        t = progAt(pc);
        if (t.op == OP_JUMP || t.op == OP_BRMISS) begin
            return t.target;
        end else if (t.op == OP_SYSCALL) begin
            return DEF_EXC_VECTOR;
        end
        return pc + PC_W'(1);
    endfunction

    function automatic logic isMem(input instrT t);
        return t.valid && (t.op == OP_LOAD || t.op == OP_STORE);
    endfunction

    initial begin
        errCount    = 0;
        retiredCnt  = 0;
        reqCnt      = 0;
        memRetired  = 0;
        outstanding = 0;
        modelDone   = 1'b0;
        expPc       = RESET_PC;
        memPc       = RESET_PC;
    end

    // Next memory op on the architectural path
    task automatic checkRequest();
        instrT tok;
        int    guard;
        tok   = progAt(memPc);
        guard = 0;
        while (tok.valid && !isMem(tok) && guard < 1024) begin
            memPc = archNext(memPc);
            tok   = progAt(memPc);
            guard++;
        end
        if (!isMem(tok)) begin
            errCount++;
            $display("Data request at %0t with no memory operation left in the program", $time);
        end else begin
            if (dReq.addr != tok.target || dReq.isStore != (tok.op == OP_STORE)) begin
                errCount++;
                $display("[FAIL] %0t: request for pc %h expected addr %h store %0b, got %h %0b",
                         $time, memPc, tok.target, tok.op == OP_STORE, dReq.addr, dReq.isStore);
            end
            // At most MEM2 and WB hold sent but unretired ops
            if (reqCnt - memRetired > 2) begin
                errCount++;
                $display("Duplicate data request at %0t, too far ahead of retirement", $time);
            end
            memPc = archNext(memPc);
        end
        reqCnt++;
    endtask

    task automatic checkRetire();
        instrT expTok;
        instrT nxt;
        if (modelDone) begin
            errCount++;
            $display("[FAIL] %0t: pc %h retired after the program ended", $time, retire.pc);
            return;
        end
        expTok = progAt(expPc);
        if (retire.pc != expPc) begin
            errCount++;
            $display("[FAIL] %0t: expected pc %h, retired pc %h", $time, expPc, retire.pc);
        end else if (retire.rd != expTok.rd) begin
            errCount++;
            $display("[FAIL] %0t: pc %h expected rd %0d, got %0d",
                     $time, expPc, expTok.rd, retire.rd);
        end
        if (isMem(expTok)) begin
            memRetired++;
            if (reqCnt < memRetired) begin
                errCount++;
                $display("Memory op at pc %h retired without a data request", expPc);
            end
        end
        retiredCnt++;
        expPc = archNext(expPc);
        nxt   = progAt(expPc);
        if (!nxt.valid) begin
            modelDone = 1'b1;
            if (reqCnt != memRetired) begin
                errCount++;
                $display("Request count %0d differs from memory ops retired %0d",
                         reqCnt, memRetired);
            end
        end
    endtask

    // Mid-cycle sampling, inputs and outputs settled
    always @(negedge clk) begin
        if (!arstN) begin
            if (fetchPc != RESET_PC || retire.valid || dReq.valid) begin
                errCount++;
                $display("[FAIL] %0t: reset state pc %h retire %0b req %0b",
                         $time, fetchPc, retire.valid, dReq.valid);
            end
        end else begin
            if (dReq.valid) begin
                checkRequest();
                outstanding++;
                if (outstanding > DCACHE_CREDITS) begin
                    errCount++;
                    $display("Outstanding requests exceed the credit pool at %0t", $time);
                end
            end
            if (dCredit) begin
                outstanding--;
            end
            if (retire.valid) begin
                checkRetire();
            end
        end
    end

endmodule

`default_nettype wire

//--- pipeTop.sv
`default_nettype none

module pipeTop (
    input  logic                          clk,
    input  logic                          arstN,
    input  pipeCtrlPkg::instrT            fetchInstr,
    input  logic                          dCredit,
    input  logic                          cfgWrEn,
    input  logic                          cfgSel,
    input  logic [pipeCtrlPkg::CFG_W-1:0] cfgData,
    output logic [pipeCtrlPkg::PC_W-1:0]  fetchPc,
    output pipeCtrlPkg::dReqT             dReq,
    output pipeCtrlPkg::retireT           retire
);
    import pipeCtrlPkg::*;

    logic [CFG_W-1:0] mulDivLat;
    logic [PC_W-1:0]  excVector;
    instrT            idInstr;
    instrT            exeInstr;
    instrT            mem1Instr;
    instrT            mem2Instr;
    hazardT           hazard;
    stageCtrlT        ctrl;
    // Current stall reason from the controller
    stallCauseE       stallCause;
    logic             dcacheBusy;
    logic             mdBusy;
    logic             jumpInId;
    logic             brMissInExe;
    logic             exceptInMem1;

    pipeConfig pipeConfig_inst (
        .clk, .arstN, .cfgWrEn, .cfgSel, .cfgData, .mulDivLat, .excVector
    );

    hazardDetect hazardDetect_inst (
        .idInstr, .exeInstr, .mem1Instr, .mem2Instr, .hazard
    );

    pipeControl pipeControl_inst (
        .dcacheBusy, .mdBusy, .exceptInMem1, .hazard, .brMissInExe, .jumpInId,
        .ctrl, .cause(stallCause)
    );

    // EXE written means a new token enters EXE
    mulDivSeq mulDivSeq_inst (
        .clk, .arstN, .exeInstr, .exeWr(ctrl.wr[S_EXE]), .mulDivLat, .mdBusy
    );

    // MEM1 written means its memory op moves on
    dcacheCredit dcacheCredit_inst (
        .clk, .arstN, .mem1Instr, .mem1Wr(ctrl.wr[S_MEM1]), .dCredit, .dReq, .dcacheBusy
    );

    stageRegs stageRegs_inst (
        .clk, .arstN, .ctrl, .fetchInstr, .excVector, .fetchPc,
        .idInstr, .exeInstr, .mem1Instr, .mem2Instr,
        .jumpInId, .brMissInExe, .exceptInMem1, .retire
    );

endmodule

`default_nettype wire

//--- pipeTop_asserts.sv
`default_nettype none

module pipeTop_asserts (
    input logic                                clk,
    input logic                                arstN,
    input pipeCtrlPkg::stageCtrlT              ctrl,
    input pipeCtrlPkg::stallCauseE             cause,
    input logic                                dcacheBusy,
    input logic                                dCredit,
    input logic [pipeCtrlPkg::CREDIT_W-1:0]    creditCnt,
    input logic                                dReqValid
);
    timeunit 1ns;
    timeprecision 100ps;
    import pipeCtrlPkg::*;

    // Out of credit wins the chain, frozen pipe drops and sends nothing
    dcacheHoldNoFlush: assert property (@(posedge clk) disable iff (!arstN)
        dcacheBusy |-> (cause == CAUSE_DCACHE && ctrl.wr == '0 && ctrl.flush == '0
                        && !dReqValid))
        else $error("Flush, write or request during a data-cache stall");

    creditBound: assert property (@(posedge clk) disable iff (!arstN)
        creditCnt <= CREDIT_W'(DCACHE_CREDITS))
        else $error("Credit count above the pool size");

    // Request without a returned credit uses one up
    // Zero-credit request wraps the count and trips the bound above
    reqNeedsCredit: assert property (@(posedge clk) disable iff (!arstN)
        (dReqValid && !dCredit) |=> (creditCnt == $past(creditCnt) - 1'b1))
        else $error("Data request did not take a credit");

endmodule

bind pipeTop pipeTop_asserts pipeTop_asserts_inst (
    .clk, .arstN, .ctrl, .cause(stallCause), .dcacheBusy, .dCredit,
    .creditCnt(dcacheCredit_inst.creditCnt), .dReqValid(dReq.valid)
);

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_pipeTop -o simv \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -q "Testbench passed" sim.log && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }

//--- stageRegs.sv
`default_nettype none

module stageRegs (
    input  logic                         clk,
    input  logic                         arstN,
    input  pipeCtrlPkg::stageCtrlT       ctrl,
    input  pipeCtrlPkg::instrT           fetchInstr,
    input  logic [pipeCtrlPkg::PC_W-1:0] excVector,
    output logic [pipeCtrlPkg::PC_W-1:0] fetchPc,
    output pipeCtrlPkg::instrT           idInstr,
    output pipeCtrlPkg::instrT           exeInstr,
    output pipeCtrlPkg::instrT           mem1Instr,
    output pipeCtrlPkg::instrT           mem2Instr,
    output logic                         jumpInId,
    output logic                         brMissInExe,
    output logic                         exceptInMem1,
    output pipeCtrlPkg::retireT          retire
);
    import pipeCtrlPkg::*;

    logic [PC_W-1:0] nextPc;
    instrT           tok   [S_IF:S_WB];
    instrT           tokIn [S_IF:S_WB];

    // Redirect sources decoded from held tokens
    assign jumpInId     = tok[S_ID].valid && (tok[S_ID].op == OP_JUMP);
    assign brMissInExe  = tok[S_EXE].valid && (tok[S_EXE].op == OP_BRMISS);
    assign exceptInMem1 = tok[S_MEM1].valid && (tok[S_MEM1].op == OP_SYSCALL);

    // Same order as the controller chain
    always_comb begin
        if (exceptInMem1) begin
            nextPc = excVector;
        end else if (brMissInExe) begin
            nextPc = tok[S_EXE].target;
        end else if (jumpInId) begin
            nextPc = tok[S_ID].target;
        end else begin
            nextPc = fetchPc + PC_W'(1);
        end
    end

    // IF loads the fetched word tagged with the PC that fetched it
    always_comb begin
        tokIn[S_IF]    = fetchInstr;
        tokIn[S_IF].pc = fetchPc;
        for (int k = S_ID; k <= S_WB; k++) begin
            tokIn[k] = tok[k-1];
        end
    end

    // PREIF is the PC register itself
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchPc <= RESET_PC;
            for (int k = S_IF; k <= S_WB; k++) begin
                tok[k] <= '0;
            end
        end else begin
            if (ctrl.wr[S_PREIF]) begin
                fetchPc <= nextPc;
            end
            // Flush beats write
            for (int k = S_IF; k <= S_WB; k++) begin
                if (ctrl.flush[k]) begin
                    tok[k] <= '0;
                end else if (ctrl.wr[k]) begin
                    tok[k] <= tokIn[k];
                end
            end
        end
    end

    assign idInstr   = tok[S_ID];
    assign exeInstr  = tok[S_EXE];
    assign mem1Instr = tok[S_MEM1];
    assign mem2Instr = tok[S_MEM2];

    // Retires as it leaves WB
    always_comb begin
        retire.valid = tok[S_WB].valid && ctrl.wr[S_WB];
        retire.pc    = tok[S_WB].pc;
        retire.rd    = tok[S_WB].rd;
    end

endmodule

`default_nettype wire

//--- tb_pipeTop.sv
`default_nettype none

module tb_pipeTop;
    timeunit 1ns;
    timeprecision 100ps;
    import pipeCtrlPkg::*;

    localparam int PROG_LEN        = 256;
    localparam int MAIN_LEN        = 224;
    localparam int HANDLER_BASE    = 240;
    localparam int HANDLER_LEN     = 7;
    localparam int CLK_NS          = 10;
    localparam int CFG_CYCLE       = 250;
    localparam int MAX_MD_LAT      = 4;
    localparam int WATCHDOG_CYCLES = PROG_LEN * (MAX_MD_LAT + 8);

    logic             clk;
    logic             arstN;
    instrT            fetchInstr;
    logic             dCredit;
    logic             cfgWrEn;
    logic             cfgSel;
    logic [CFG_W-1:0] cfgData;
    logic [PC_W-1:0]  fetchPc;
    dReqT             dReq;
    retireT           retire;

    instrT  prog [PROG_LEN];
    integer seed;
    int     cycleCnt;
    int     creditDue [$];
    int     errCount;
    int     retiredCnt;
    int     reqCnt;
    logic   modelDone;

    pipeTop pipeTop_inst (
        .clk, .arstN, .fetchInstr, .dCredit, .cfgWrEn, .cfgSel, .cfgData,
        .fetchPc, .dReq, .retire
    );

    pipeMonitor pipeMonitor_inst (
        .clk, .arstN, .prog, .fetchPc, .dReq, .dCredit, .retire,
        .errCount, .retiredCnt, .reqCnt, .modelDone
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    // Main program low, exception handler mapped to table top
    function automatic instrT fetchLookup(input logic [PC_W-1:0] pc);
        logic [7:0] idx;
        if (pc < PC_W'(HANDLER_BASE)) begin
            return prog[pc[7:0]];
        end else if (pc >= DEF_EXC_VECTOR && pc < DEF_EXC_VECTOR + PC_W'(16)) begin
            idx = 8'(HANDLER_BASE) + 8'(pc - DEF_EXC_VECTOR);
            return prog[idx];
        end
        return '0;
    endfunction

    // Registers 0 to 7 only, so hazards are frequent
    task automatic makeToken(input logic [PC_W-1:0] pc, input bit allowFlow,
                             output instrT tok);
        logic [31:0] r;
        int          t;
        r          = $random(seed);
        tok        = '0;
        tok.valid  = 1'b1;
        tok.pc     = pc;
        tok.rs     = {2'b00, r[6:4]};
        tok.rt     = {2'b00, r[9:7]};
        tok.rd     = {2'b00, r[12:10]};
        case (r[3:0])
            4'd6, 4'd7, 4'd8: tok.op = OP_LOAD;
            4'd9, 4'd10:      tok.op = OP_STORE;
            4'd11, 4'd12:     tok.op = OP_MULDIV;
            4'd13:            tok.op = allowFlow ? OP_JUMP : OP_ALU;
            4'd14:            tok.op = allowFlow ? OP_BRMISS : OP_ALU;
            default:          tok.op = OP_ALU;
        endcase
        r = $random(seed);
        if (tok.op == OP_JUMP || tok.op == OP_BRMISS) begin
            // Forward targets only, so the program always ends
            t = int'(pc) + 1 + int'(r[2:0]);
            if (t > MAIN_LEN - 1) begin
                t = MAIN_LEN - 1;
            end
            tok.target = PC_W'(t);
            tok.rd     = '0;
        end else begin
            tok.target = r[15:0];
        end
        if (tok.op == OP_STORE) begin
            tok.rd = '0;
        end
    endtask

    task automatic buildProgram();
        instrT tok;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = '0;
        end
        for (int i = 0; i < MAIN_LEN - 1; i++) begin
            makeToken(PC_W'(i), 1'b1, tok);
            prog[i] = tok;
        end
        // Program ends in a syscall
        tok        = '0;
        tok.valid  = 1'b1;
        tok.op     = OP_SYSCALL;
        tok.pc     = PC_W'(MAIN_LEN - 1);
        prog[MAIN_LEN - 1] = tok;
        // Straight-line handler, entry after it left invalid as END
        for (int k = 0; k < HANDLER_LEN; k++) begin
            makeToken(DEF_EXC_VECTOR + PC_W'(k), 1'b0, tok);
            prog[HANDLER_BASE + k] = tok;
        end
    endtask

    // Stimulus, 1 ns after each rising edge
    initial begin
        seed       = 32'h44e9;
        buildProgram();
        cycleCnt   = 0;
        arstN      = 1'b0;
        dCredit    = 1'b0;
        cfgWrEn    = 1'b0;
        cfgSel     = 1'b0;
        cfgData    = '0;
        fetchInstr = fetchLookup(RESET_PC);
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            cycleCnt++;
            fetchInstr = fetchLookup(fetchPc);
            dCredit    = 1'b0;
            if (creditDue.size() > 0 && creditDue[0] <= cycleCnt) begin
                void'(creditDue.pop_front());
                dCredit = 1'b1;
            end
            // One latency write midway
            cfgWrEn = (cycleCnt == CFG_CYCLE);
            cfgSel  = 1'b0;
            cfgData = 16'd2;
        end
    end

    // Each request gets its credit back 1 to 4 cycles later
    always @(negedge clk) begin
        logic [31:0] r;
        if (arstN && dReq.valid) begin
            r = $random(seed);
            creditDue.push_back(cycleCnt + 1 + int'(r[1:0]));
        end
    end

    // End of program plus drain time
    initial begin
        wait (arstN === 1'b1);
        wait (modelDone === 1'b1);
        repeat (20) @(posedge clk);
        $display("Summary: %0d retired, %0d data requests, %0d errors",
                 retiredCnt, reqCnt, errCount);
        if (errCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #((WATCHDOG_CYCLES + 3) * CLK_NS);
        $display("Timeout: program did not finish within %0d cycles, %0d retired, %0d errors",
                 WATCHDOG_CYCLES, retiredCnt, errCount);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
